//--- project.f
source/cpuPkg.sv
source/instructionDecoder.sv
source/registerFile.sv
source/alu.sv
source/hazardForward.sv
source/datapath.sv
source/cpuTop.sv
verification/cpuCheck_assert.sv
verification/cpuTb.sv

//--- Makefile
VERILATOR = verilator
TOP = cpuTb
FILELIST = project.f
BUILD_DIR = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS = --binary --timing --assert -Wno-fatal
RUN_FLAGS = +verilator+error+limit+1000
PASS_MSG = test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- verification/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    logic Clk;
    logic rstN;
    logic m1Busy;
    logic m2Busy;
    logic [15:0] data1;
    logic [15:0] dataRead;
    logic readM1;
    logic readM2;
    logic writeM2;
    logic [15:0] address1;
    logic [15:0] address2;
    logic [15:0] dataWrite;
    logic halted;
    logic [15:0] numInst;
    logic [15:0] outputPort;

    logic [15:0] imem [256];
    logic [15:0] dmem [256];
    logic [15:0] expOut [8];
    logic [31:0] lcgState;
    logic [15:0] lastOut;
    logic [15:0] fetchAddr;
    logic fetchActive;
    logic memActive;
    int fetchWait;
    int memWait;
    int outIndex;
    int valueErrors;
    int timeoutErrors;
    int cycles;

    cpuTop dut_i (
        .Clk(Clk), .rstN(rstN), .m1Busy(m1Busy), .m2Busy(m2Busy),
        .data1(data1), .dataRead(dataRead), .readM1(readM1), .readM2(readM2),
        .writeM2(writeM2), .address1(address1), .address2(address2),
        .dataWrite(dataWrite), .halted(halted), .numInst(numInst),
        .outputPort(outputPort)
    );

    always #20 Clk = ~Clk;

    function automatic logic [15:0] encodeR(input logic [1:0] rs, input logic [1:0] rt,
                                            input logic [1:0] rd, input logic [5:0] fn);
        return {rTypeOp, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] encodeI(input logic [3:0] op, input logic [1:0] rs,
                                            input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // 0 to 3 busy cycles per access
    function automatic int nextLatency();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return int'(lcgState[17:16]);
    endfunction

    task automatic loadProgram();
        for (int i = 0; i < 256; i++) begin
            imem[i] = 16'h0000;
            dmem[i] = 16'hC3A5 ^ {i[7:0], i[7:0]};
        end
        imem[0] = encodeI(adiOp, 2'd0, 2'd1, 8'd5);
        imem[1] = encodeR(2'd1, 2'd1, 2'd2, funcAdd);
        imem[2] = encodeR(2'd2, 2'd0, 2'd0, funcWwd);
        imem[3] = encodeR(2'd2, 2'd1, 2'd3, funcSub);
        imem[4] = encodeR(2'd3, 2'd0, 2'd0, funcWwd);
        imem[5] = encodeR(2'd2, 2'd0, 2'd1, funcShl);
        imem[6] = encodeR(2'd1, 2'd0, 2'd0, funcWwd);
        imem[7] = encodeI(lhiOp, 2'd0, 2'd0, 8'h12);
        imem[8] = encodeR(2'd0, 2'd0, 2'd0, funcWwd);
        imem[9] = encodeI(adiOp, 2'd2, 2'd3, 8'd3);
        imem[10] = encodeI(swdOp, 2'd3, 2'd1, 8'd4);
        imem[11] = encodeI(lwdOp, 2'd3, 2'd0, 8'd4);
        imem[12] = encodeR(2'd0, 2'd3, 2'd2, funcAdd);
        imem[13] = encodeR(2'd2, 2'd0, 2'd0, funcWwd);
        imem[14] = encodeI(beqOp, 2'd1, 2'd0, 8'd1);
        imem[15] = encodeR(2'd3, 2'd0, 2'd0, funcWwd);
        imem[16] = encodeI(bneOp, 2'd1, 2'd0, 8'd2);
        imem[17] = encodeI(adiOp, 2'd3, 2'd3, 8'd1);
        imem[18] = encodeR(2'd3, 2'd0, 2'd0, funcWwd);
        imem[19] = {jmpOp, 12'd21};
        imem[20] = encodeR(2'd0, 2'd0, 2'd0, funcWwd);
        imem[21] = {jalOp, 12'd25};
        imem[22] = encodeR(2'd2, 2'd0, 2'd0, funcWwd);
        imem[23] = encodeR(2'd0, 2'd0, 2'd0, funcHlt);
        imem[24] = encodeR(2'd3, 2'd0, 2'd0, funcWwd);
        imem[25] = encodeI(adiOp, 2'd3, 2'd3, 8'd5);
        imem[26] = encodeR(2'd3, 2'd0, 2'd0, funcWwd);
        imem[27] = encodeR(2'd2, 2'd0, 2'd0, funcJpr);
        imem[28] = encodeR(2'd1, 2'd0, 2'd0, funcWwd);
        imem[29] = encodeR(2'd0, 2'd0, 2'd0, funcWwd);
        // r1=5, r2=r1+r1, r3=r2-r1, r1=r2<<1, r0=0x12<<8, r2=mem[17]+r3,
        // r3+1, r3+5, then the JAL link value
        expOut[0] = 16'd10;
        expOut[1] = 16'd5;
        expOut[2] = 16'd20;
        expOut[3] = 16'h1200;
        expOut[4] = 16'd20 + 16'd13;
        expOut[5] = 16'd14;
        expOut[6] = 16'd19;
        expOut[7] = 16'd22;
    endtask

    // instruction memory picks a new latency for every fetch attempt
    always @(negedge Clk) begin
        if (!readM1) begin
            m1Busy <= 1'b0;
            fetchActive = 1'b0;
        end else begin
            if (!fetchActive || address1 != fetchAddr) begin
                fetchActive = 1'b1;
                fetchAddr = address1;
                fetchWait = nextLatency();
            end
            if (fetchWait > 0) begin
                fetchWait--;
                m1Busy <= 1'b1;
                data1 <= 16'h0000;
            end else begin
                m1Busy <= 1'b0;
                data1 <= imem[address1[7:0]];
                fetchActive = 1'b0;
            end
        end
    end

    // data memory applies a store in the cycle busy falls
    always @(negedge Clk) begin
        if (!rstN || !(readM2 || writeM2)) begin
            m2Busy <= 1'b0;
            memActive = 1'b0;
        end else begin
            if (!memActive) begin
                memActive = 1'b1;
                memWait = nextLatency();
            end
            if (memWait > 0) begin
                memWait--;
                m2Busy <= 1'b1;
            end else begin
                m2Busy <= 1'b0;
                memActive = 1'b0;
                if (writeM2) begin
                    dmem[address2[7:0]] = dataWrite;
                end
                dataRead <= dmem[address2[7:0]];
            end
        end
    end

    always @(negedge Clk) begin
        if (rstN && outputPort != lastOut) begin
            assert (outIndex < 8) else begin
                valueErrors++;
                $display("unexpected extra output value %h", outputPort);
            end
            if (outIndex < 8) begin
                assert (outputPort == expOut[outIndex]) else begin
                    valueErrors++;
                    $display("FAIL wwdSequence[%0d] expected %h actual %h",
                             outIndex, expOut[outIndex], outputPort);
                end
            end
            outIndex++;
            lastOut = outputPort;
        end
    end

    initial begin
        Clk = 1'b0;
        rstN = 1'b0;
        m1Busy = 1'b0;
        m2Busy = 1'b0;
        data1 = 16'h0000;
        dataRead = 16'h0000;
        lcgState = 32'd2;
        lastOut = 16'h0000;
        fetchActive = 1'b0;
        memActive = 1'b0;
        fetchWait = 0;
        memWait = 0;
        outIndex = 0;
        valueErrors = 0;
        timeoutErrors = 0;
        loadProgram();

        repeat (16) @(negedge Clk);
        rstN = 1'b1;
        #1;
        assert (!readM2 && !writeM2 && !halted) else begin
            valueErrors++;
            $display("memory strobe or halted high right after reset");
        end
        assert (numInst == 16'd0) else begin
            valueErrors++;
            $display("FAIL resetCount expected 0 actual %0d", numInst);
        end
        assert (address1 == 16'd0) else begin
            valueErrors++;
            $display("FAIL resetPc expected 0 actual %h", address1);
        end

        cycles = 0;
        while (!halted && cycles < 3000) begin
            @(negedge Clk);
            cycles++;
        end
        if (!halted) begin
            timeoutErrors++;
            $display("timed out waiting for the core to halt");
        end

        cycles = 0;
        while (cycles < 5) begin
            @(negedge Clk);
            cycles++;
        end
        assert (halted && !readM1) else begin
            valueErrors++;
            $display("core not halted or still fetching after HLT");
        end
        assert (numInst == 16'd25) else begin
            valueErrors++;
            $display("FAIL retiredCount expected 25 actual %0d", numInst);
        end
        assert (outIndex == 8) else begin
            valueErrors++;
            $display("FAIL wwdCount expected 8 actual %0d", outIndex);
        end

        $display("errors: value %0d, timeout %0d, assertion %0d", valueErrors,
                 timeoutErrors, dut_i.datapathInst.checkInst.failCount);
        if (valueErrors == 0 && timeoutErrors == 0 &&
            dut_i.datapathInst.checkInst.failCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verification/cpuCheck_assert.sv
`timescale 1ns/1ps

module cpuCheck_assert (
    input logic Clk,
    input logic rstN,
    input logic readM2,
    input logic writeM2,
    input logic halted,
    input logic [cpuPkg::wordSize-1:0] numInst
);
    int failCount;

    initial begin
        failCount = 0;
    end

    // one data access kind at a time
    memExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        !(readM2 && writeM2))
        else begin
            failCount++;
            $error("readM2 and writeM2 high together");
        end

    // at most one retirement per cycle and none once halted
    countStep: assert property (@(posedge Clk) disable iff (!rstN)
        (numInst == $past(numInst)) ||
        (!$past(halted) && numInst == $past(numInst) + 16'd1))
        else begin
            failCount++;
            $error("numInst stepped by more than one or moved after halt");
        end

    haltHolds: assert property (@(posedge Clk) disable iff (!rstN)
        halted |=> halted)
        else begin
            failCount++;
            $error("halted dropped before reset");
        end

endmodule

bind datapath cpuCheck_assert checkInst (
    .Clk(Clk),
    .rstN(rstN),
    .readM2(readM2),
    .writeM2(writeM2),
    .halted(halted),
    .numInst(numInst)
);

//--- source/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic Clk,
    input  logic rstN,
    input  logic m1Busy,
    input  logic m2Busy,
    input  logic [cpuPkg::wordSize-1:0] data1,
    input  logic [cpuPkg::wordSize-1:0] dataRead,
    output logic readM1,
    output logic readM2,
    output logic writeM2,
    output logic [cpuPkg::wordSize-1:0] address1,
    output logic [cpuPkg::wordSize-1:0] address2,
    output logic [cpuPkg::wordSize-1:0] dataWrite,
    output logic halted,
    output logic [cpuPkg::wordSize-1:0] numInst,
    output logic [cpuPkg::wordSize-1:0] outputPort
);
    import cpuPkg::*;

    logic [ctlWidth-1:0] controls;
    instructionT ifIdInstruction;

    // decoder answers in the same cycle the instruction sits in ID
    instructionDecoder decoderInst (
        .instruction(ifIdInstruction),
        .controls(controls)
    );

    datapath datapathInst (
        .Clk(Clk),
        .rstN(rstN),
        .controls(controls),
        .data1(data1),
        .dataRead(dataRead),
        .m1Busy(m1Busy),
        .m2Busy(m2Busy),
        .ifIdInstruction(ifIdInstruction),
        .readM1(readM1),
        .address1(address1),
        .readM2(readM2),
        .writeM2(writeM2),
        .address2(address2),
        .dataWrite(dataWrite),
        .halted(halted),
        .numInst(numInst),
        .outputPort(outputPort)
    );

endmodule

//--- source/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic Clk,
    input  logic rstN,
    input  logic [cpuPkg::ctlWidth-1:0] controls,
    input  logic [cpuPkg::wordSize-1:0] data1,
    input  logic [cpuPkg::wordSize-1:0] dataRead,
    input  logic m1Busy,
    input  logic m2Busy,
    output cpuPkg::instructionT ifIdInstruction,
    output logic readM1,
    output logic [cpuPkg::wordSize-1:0] address1,
    output logic readM2,
    output logic writeM2,
    output logic [cpuPkg::wordSize-1:0] address2,
    output logic [cpuPkg::wordSize-1:0] dataWrite,
    output logic halted,
    output logic [cpuPkg::wordSize-1:0] numInst,
    output logic [cpuPkg::wordSize-1:0] outputPort
);
    import cpuPkg::*;

    logic [wordSize-1:0] pc;
    logic [wordSize-1:0] pcNext;
    logic [wordSize-1:0] pcPlusOne;

    // pc fields hold the address after the instruction
    logic ifIdValid;
    logic [wordSize-1:0] ifIdPc;

    logic idExValid;
    logic [ctlWidth-1:0] idExCtl;
    logic [wordSize-1:0] idExPc;
    logic [wordSize-1:0] idExData1;
    logic [wordSize-1:0] idExData2;
    logic [wordSize-1:0] idExImm;
    logic [1:0] idExRs;
    logic [1:0] idExRt;
    logic [1:0] idExRd;
    logic [3:0] idExOpcode;
    logic [5:0] idExFunc;

    logic exMemValid;
    logic exMemIsHlt;
    logic [ctlMemRead:0] exMemCtl;
    logic [wordSize-1:0] exMemAluOut;
    logic [wordSize-1:0] exMemStoreData;
    logic [1:0] exMemRd;

    logic memWbValid;
    logic memWbIsHlt;
    logic [ctlMemToReg:0] memWbCtl;
    logic [wordSize-1:0] memWbAluOut;
    logic [wordSize-1:0] memWbReadData;
    logic [1:0] memWbRd;

    logic [3:0] idOpcode;
    logic [1:0] idRd;
    logic useRs;
    logic useRt;
    logic [wordSize-1:0] idData1;
    logic [wordSize-1:0] idData2;
    logic idJump;
    logic loadStall;

    logic [1:0] forwardA;
    logic [1:0] forwardB;
    logic [wordSize-1:0] fwdA;
    logic [wordSize-1:0] fwdB;
    logic [wordSize-1:0] aluA;
    logic [wordSize-1:0] aluB;
    logic [wordSize-1:0] aluResult;
    logic [wordSize-1:0] exTarget;
    logic branchTaken;
    logic isLink;
    logic exRedirect;

    logic memStall;
    logic haltNow;
    logic [wordSize-1:0] wbData;

    assign readM1 = !halted;
    assign address1 = pc;
    assign readM2 = exMemCtl[ctlMemRead];
    assign writeM2 = exMemCtl[ctlMemWrite];
    assign address2 = exMemAluOut;
    assign dataWrite = exMemStoreData;

    assign pcPlusOne = pc + wordSize'(1);
    assign memStall = (readM2 || writeM2) && m2Busy;
    assign haltNow = memWbValid && memWbIsHlt;

    assign idOpcode = ifIdInstruction.r.opcode;
    assign idJump = ifIdValid && controls[ctlIsJumpI];
    // links always go to register 2
    assign idRd = (controls[ctlRegWrite] && (controls[ctlIsJumpI] || controls[ctlIsJumpR])) ?
                  2'd2 : controls[ctlRegDst] ? ifIdInstruction.r.rd : ifIdInstruction.r.rt;
    assign useRs = ifIdValid && !(idOpcode == jmpOp || idOpcode == jalOp || idOpcode == lhiOp);
    assign useRt = ifIdValid &&
                   ((idOpcode == rTypeOp && (ifIdInstruction.r.func == funcAdd ||
                                             ifIdInstruction.r.func == funcSub ||
                                             ifIdInstruction.r.func == funcAnd ||
                                             ifIdInstruction.r.func == funcOrr)) ||
                    idOpcode == swdOp || idOpcode == bneOp || idOpcode == beqOp);

    assign fwdA = (forwardA == 2'b01) ? exMemAluOut : (forwardA == 2'b10) ? wbData : idExData1;
    assign fwdB = (forwardB == 2'b01) ? exMemAluOut : (forwardB == 2'b10) ? wbData : idExData2;
    assign isLink = idExCtl[ctlRegWrite] && (idExCtl[ctlIsJumpI] || idExCtl[ctlIsJumpR]);
    assign aluA = isLink ? idExPc : fwdA;
    assign aluB = idExCtl[ctlAluSrc] ? idExImm : fwdB;
    assign exTarget = idExCtl[ctlIsJumpR] ? fwdA : idExPc + idExImm;
    // bubbles carry zero controls, so no valid term is needed here
    assign exRedirect = branchTaken || idExCtl[ctlIsJumpR];

    assign wbData = memWbCtl[ctlMemToReg] ? memWbReadData : memWbAluOut;

    always_comb begin
        if (halted || memStall || loadStall) begin
            pcNext = pc;
        end else if (exRedirect) begin
            pcNext = exTarget;
        end else if (idJump) begin
            pcNext = {ifIdPc[wordSize-1:12], ifIdInstruction.j.target12};
        end else if (!m1Busy) begin
            pcNext = pcPlusOne;
        end else begin
            pcNext = pc;
        end
    end

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
            ifIdValid <= 1'b0;
            idExValid <= 1'b0;
            idExCtl <= '0;
            exMemValid <= 1'b0;
            exMemCtl <= '0;
            exMemIsHlt <= 1'b0;
            memWbValid <= 1'b0;
            memWbCtl <= '0;
            memWbIsHlt <= 1'b0;
            halted <= 1'b0;
            numInst <= '0;
            outputPort <= '0;
        end else begin
            pc <= pcNext;

            // retirement
            if (memWbValid) begin
                numInst <= numInst + 1'b1;
                if (memWbCtl[ctlWwd]) begin
                    outputPort <= memWbAluOut;
                end
                if (memWbIsHlt) begin
                    halted <= 1'b1;
                end
            end

            if (haltNow || halted) begin
                ifIdValid <= 1'b0;
                idExValid <= 1'b0;
                idExCtl <= '0;
                exMemValid <= 1'b0;
                exMemCtl <= '0;
                exMemIsHlt <= 1'b0;
                memWbValid <= 1'b0;
                memWbCtl <= '0;
                memWbIsHlt <= 1'b0;
            end else begin
                // a busy data access sends a bubble to WB
                memWbValid <= exMemValid && !memStall;
                memWbCtl <= memStall ? '0 : exMemCtl[ctlMemToReg:0];
                memWbIsHlt <= exMemIsHlt && !memStall;

                if (!memStall) begin
                    exMemValid <= idExValid;
                    exMemCtl <= idExCtl[ctlMemRead:0];
                    exMemIsHlt <= idExValid && idExOpcode == rTypeOp && idExFunc == funcHlt;
                    if (loadStall || exRedirect) begin
                        idExValid <= 1'b0;
                        idExCtl <= '0;
                    end else begin
                        idExValid <= ifIdValid;
                        idExCtl <= ifIdValid ? controls : '0;
                    end
                    if (!loadStall) begin
                        ifIdValid <= !(exRedirect || idJump || m1Busy);
                    end
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!memStall && !loadStall) begin
            ifIdInstruction <= data1;
            ifIdPc <= pcPlusOne;
        end

        if (memStall) begin
            // WB leaves while EX waits, so keep the forwarded operands
            idExData1 <= fwdA;
            idExData2 <= fwdB;
        end else begin
            idExPc <= ifIdPc;
            idExData1 <= idData1;
            idExData2 <= idData2;
            idExImm <= {{8{ifIdInstruction.i.imm8[7]}}, ifIdInstruction.i.imm8};
            idExRs <= ifIdInstruction.r.rs;
            idExRt <= ifIdInstruction.r.rt;
            idExRd <= idRd;
            idExOpcode <= idOpcode;
            idExFunc <= ifIdInstruction.r.func;
        end

        if (!memStall) begin
            exMemAluOut <= aluResult;
            exMemStoreData <= fwdB;
            exMemRd <= idExRd;
        end

        memWbAluOut <= exMemAluOut;
        memWbReadData <= dataRead;
        memWbRd <= exMemRd;
    end

    registerFile regFileInst (
        .Clk(Clk),
        .rstN(rstN),
        .readAddr1(ifIdInstruction.r.rs),
        .readAddr2(ifIdInstruction.r.rt),
        .writeAddr(memWbRd),
        .writeData(wbData),
        .writeEnable(memWbCtl[ctlRegWrite]),
        .readData1(idData1),
        .readData2(idData2)
    );

    alu aluInst (
        .opA(aluA),
        .opB(aluB),
        .isAlu(idExCtl[ctlIsAlu]),
        .opcode(idExOpcode),
        .func(idExFunc),
        .branchType(idExCtl[ctlIsBranch]),
        .result(aluResult),
        .branchTaken(branchTaken)
    );

    hazardForward hazardInst (
        .idRs(ifIdInstruction.r.rs),
        .idRt(ifIdInstruction.r.rt),
        .useRs(useRs),
        .useRt(useRt),
        .idExMemRead(idExCtl[ctlMemRead]),
        .idExRd(idExRd),
        .exMemRegWrite(exMemCtl[ctlRegWrite]),
        .exMemRd(exMemRd),
        .memWbRegWrite(memWbCtl[ctlRegWrite]),
        .memWbRd(memWbRd),
        .idExRs(idExRs),
        .idExRt(idExRt),
        .forwardA(forwardA),
        .forwardB(forwardB),
        .loadStall(loadStall)
    );

endmodule

//--- source/hazardForward.sv
`timescale 1ns/1ps

module hazardForward (
    input  logic [1:0] idRs,
    input  logic [1:0] idRt,
    input  logic useRs,
    input  logic useRt,
    input  logic idExMemRead,
    input  logic [1:0] idExRd,
    input  logic exMemRegWrite,
    input  logic [1:0] exMemRd,
    input  logic memWbRegWrite,
    input  logic [1:0] memWbRd,
    input  logic [1:0] idExRs,
    input  logic [1:0] idExRt,
    output logic [1:0] forwardA,
    output logic [1:0] forwardB,
    output logic loadStall
);

    // 01 takes EX/MEM, 10 takes MEM/WB, the younger result wins
    assign forwardA = (exMemRegWrite && exMemRd == idExRs) ? 2'b01 :
                      (memWbRegWrite && memWbRd == idExRs) ? 2'b10 : 2'b00;
    assign forwardB = (exMemRegWrite && exMemRd == idExRt) ? 2'b01 :
                      (memWbRegWrite && memWbRd == idExRt) ? 2'b10 : 2'b00;

    // load data only exists after MEM, so a direct consumer waits one cycle
    assign loadStall = idExMemRead &&
                       ((useRs && idRs == idExRd) || (useRt && idRt == idExRd));

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpuPkg::wordSize-1:0] opA,
    input  logic [cpuPkg::wordSize-1:0] opB,
    input  logic isAlu,
    input  logic [3:0] opcode,
    input  logic [5:0] func,
    input  logic branchType,
    output logic [cpuPkg::wordSize-1:0] result,
    output logic branchTaken
);
    import cpuPkg::*;

    logic [3:0] aluOp;
    logic branchCond;

    // non-ALU instructions add (address calc) or pass rs / link value
    always_comb begin
        aluOp = aluAdd;
        if (isAlu) begin
            case (opcode)
                oriOp: aluOp = aluOri;
                lhiOp: aluOp = aluLhi;
                rTypeOp: begin
                    case (func)
                        funcSub: aluOp = aluSub;
                        funcAnd: aluOp = aluAnd;
                        funcOrr: aluOp = aluOrr;
                        funcNot: aluOp = aluNot;
                        funcTcp: aluOp = aluTcp;
                        funcShl: aluOp = aluShl;
                        funcShr: aluOp = aluShr;
                        default: aluOp = aluAdd;
                    endcase
                end
                default: aluOp = aluAdd;
            endcase
        end else if (opcode == rTypeOp || opcode == jalOp) begin
            aluOp = aluPassA;
        end
    end

    always_comb begin
        case (aluOp)
            aluSub: result = opA - opB;
            aluAnd: result = opA & opB;
            aluOrr: result = opA | opB;
            aluNot: result = ~opA;
            aluTcp: result = ~opA + wordSize'(1);
            aluShl: result = {opA[wordSize-2:0], 1'b0};
            aluShr: result = {opA[wordSize-1], opA[wordSize-1:1]};
            aluLhi: result = {opB[7:0], 8'h00};
            // ORI takes the immediate zero extended
            aluOri: result = opA | {8'h00, opB[7:0]};
            aluPassA: result = opA;
            default: result = opA + opB;
        endcase
    end

    always_comb begin
        case (opcode)
            bneOp: branchCond = (opA != opB);
            beqOp: branchCond = (opA == opB);
            bgzOp: branchCond = !opA[wordSize-1] && (opA != '0);
            blzOp: branchCond = opA[wordSize-1];
            default: branchCond = 1'b0;
        endcase
    end

    assign branchTaken = branchType && branchCond;

endmodule

//--- source/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic Clk,
    input  logic rstN,
    input  logic [1:0] readAddr1,
    input  logic [1:0] readAddr2,
    input  logic [1:0] writeAddr,
    input  logic [cpuPkg::wordSize-1:0] writeData,
    input  logic writeEnable,
    output logic [cpuPkg::wordSize-1:0] readData1,
    output logic [cpuPkg::wordSize-1:0] readData2
);
    logic [cpuPkg::wordSize-1:0] regs [4];

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // write-first, so ID sees the value WB is writing this cycle
    assign readData1 = (writeEnable && writeAddr == readAddr1) ? writeData : regs[readAddr1];
    assign readData2 = (writeEnable && writeAddr == readAddr2) ? writeData : regs[readAddr2];

endmodule

//--- source/instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder (
    input  cpuPkg::instructionT instruction,
    output logic [cpuPkg::ctlWidth-1:0] controls
);
    import cpuPkg::*;

    always_comb begin
        controls = '0;
        case (instruction.r.opcode)
            adiOp, oriOp, lhiOp: begin
                controls[ctlRegWrite] = 1'b1;
                controls[ctlAluSrc] = 1'b1;
                controls[ctlIsAlu] = 1'b1;
            end
            lwdOp: begin
                controls[ctlRegWrite] = 1'b1;
                controls[ctlMemToReg] = 1'b1;
                controls[ctlMemRead] = 1'b1;
                controls[ctlAluSrc] = 1'b1;
            end
            swdOp: begin
                controls[ctlMemWrite] = 1'b1;
                controls[ctlAluSrc] = 1'b1;
            end
            bneOp, beqOp, bgzOp, blzOp: begin
                controls[ctlIsBranch] = 1'b1;
            end
            jmpOp: begin
                controls[ctlIsJumpI] = 1'b1;
            end
            jalOp: begin
                controls[ctlIsJumpI] = 1'b1;
                controls[ctlRegWrite] = 1'b1;
            end
            rTypeOp: begin
                case (instruction.r.func)
                    funcAdd, funcSub, funcAnd, funcOrr,
                    funcNot, funcTcp, funcShl, funcShr: begin
                        controls[ctlRegWrite] = 1'b1;
                        controls[ctlIsAlu] = 1'b1;
                        controls[ctlRegDst] = 1'b1;
                    end
                    funcWwd: begin
                        controls[ctlWwd] = 1'b1;
                    end
                    funcJpr: begin
                        controls[ctlIsJumpR] = 1'b1;
                    end
                    funcJrl: begin
                        controls[ctlIsJumpR] = 1'b1;
                        controls[ctlRegWrite] = 1'b1;
                    end
                    // HLT is recognised later in the pipe
                    default: controls = '0;
                endcase
            end
            default: controls = '0;
        endcase
    end

endmodule

//--- source/cpuPkg.sv
package cpuPkg;

    // data, address and instruction all share one word
    localparam int wordSize = 16;
    localparam int ctlWidth = 11;

    localparam logic [3:0] bneOp = 4'd0;
    localparam logic [3:0] beqOp = 4'd1;
    localparam logic [3:0] bgzOp = 4'd2;
    localparam logic [3:0] blzOp = 4'd3;
    localparam logic [3:0] adiOp = 4'd4;
    localparam logic [3:0] oriOp = 4'd5;
    localparam logic [3:0] lhiOp = 4'd6;
    localparam logic [3:0] lwdOp = 4'd7;
    localparam logic [3:0] swdOp = 4'd8;
    localparam logic [3:0] jmpOp = 4'd9;
    localparam logic [3:0] jalOp = 4'd10;
    localparam logic [3:0] rTypeOp = 4'd15;

    localparam logic [5:0] funcAdd = 6'd0;
    localparam logic [5:0] funcSub = 6'd1;
    localparam logic [5:0] funcAnd = 6'd2;
    localparam logic [5:0] funcOrr = 6'd3;
    localparam logic [5:0] funcNot = 6'd4;
    localparam logic [5:0] funcTcp = 6'd5;
    localparam logic [5:0] funcShl = 6'd6;
    localparam logic [5:0] funcShr = 6'd7;
    localparam logic [5:0] funcJpr = 6'd25;
    localparam logic [5:0] funcJrl = 6'd26;
    localparam logic [5:0] funcWwd = 6'd28;
    localparam logic [5:0] funcHlt = 6'd29;

    // WB bits sit lowest so later stages keep only a low slice
    localparam int ctlWwd = 0;
    localparam int ctlRegWrite = 1;
    localparam int ctlMemToReg = 2;
    localparam int ctlMemWrite = 3;
    localparam int ctlMemRead = 4;
    localparam int ctlIsBranch = 5;
    localparam int ctlAluSrc = 6;
    localparam int ctlIsAlu = 7;
    localparam int ctlIsJumpR = 8;
    localparam int ctlIsJumpI = 9;
    localparam int ctlRegDst = 10;

    localparam logic [3:0] aluAdd = 4'd0;
    localparam logic [3:0] aluSub = 4'd1;
    localparam logic [3:0] aluAnd = 4'd2;
    localparam logic [3:0] aluOrr = 4'd3;
    localparam logic [3:0] aluNot = 4'd4;
    localparam logic [3:0] aluTcp = 4'd5;
    localparam logic [3:0] aluShl = 4'd6;
    localparam logic [3:0] aluShr = 4'd7;
    localparam logic [3:0] aluLhi = 4'd8;
    localparam logic [3:0] aluOri = 4'd9;
    localparam logic [3:0] aluPassA = 4'd10;

    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [1:0] rs;
            logic [1:0] rt;
            logic [1:0] rd;
            logic [5:0] func;
        } r;
        struct packed {
            logic [3:0] opcode;
            logic [1:0] rs;
            logic [1:0] rt;
            logic [7:0] imm8;
        } i;
        struct packed {
            logic [3:0] opcode;
            logic [11:0] target12;
        } j;
    } instructionT;

endpackage
